// ==== fp_reduce_pkg.sv ====
package fp_reduce_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Single-precision field layout
    ////////////////////////////////////////////////////////////////////////////

    // Full IEEE-754 word
    localparam int FP_W = 32;

    // Biased exponent, 127 offset
    localparam int EXP_W = 8;

    // Stored fraction, hidden one not included
    localparam int MAN_W = 23;

    ////////////////////////////////////////////////////////////////////////////
    // Operation select
    ////////////////////////////////////////////////////////////////////////////

    // Which extreme the reducer keeps over a job
    typedef enum logic {
        OP_MAX = 1'b0,
        OP_MIN = 1'b1
    } reduce_op_e;

    ////////////////////////////////////////////////////////////////////////////
    // Controller states
    ////////////////////////////////////////////////////////////////////////////

    // ST_FIRST waits for the element that seeds the accumulator,
    // ST_ACCUM compares every further one, ST_DONE is the result cycle
    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_FIRST = 2'd1,
        ST_ACCUM = 2'd2,
        ST_DONE  = 2'd3
    } reduce_state_e;

endpackage

// ==== element_counter.sv ====
module element_counter #(
    parameter int LEN_W = 8
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             clear,
    input  logic             step,
    input  logic [LEN_W-1:0] count,
    output logic [LEN_W-1:0] index,
    output logic             last
);

    // Element count of the running job
    logic [LEN_W-1:0] count_q;

    ////////////////////////////////////////////////////////////////////////////
    // Job length and position
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            count_q <= '0;
        end else if (clear) begin
            count_q <= count;
        end
    end

    // Clear restarts at element zero
    always_ff @(posedge clk) begin
        if (rst) begin
            index <= '0;
        end else if (clear) begin
            index <= '0;
        end else if (step) begin
            index <= index + LEN_W'(1);
        end
    end

    // Current element closes the job
    assign last = (index == count_q - LEN_W'(1));

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    // The controller must stop stepping once the job is complete
    a_no_step_past_count: assert property (
        @(posedge clk) disable iff (rst)
        step |-> (index < count_q)
    ) else $error("element_counter: step after the last element");

endmodule

// ==== reduce_ctrl_fsm.sv ====
module reduce_ctrl_fsm
    import fp_reduce_pkg::*;
#(
    parameter int LEN_W = 8
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  reduce_op_e       op,
    input  logic [LEN_W-1:0] count,
    input  logic             in_stb,
    input  logic             last,
    output logic             clear,
    output logic             step,
    output logic             load_first,
    output logic             update,
    output reduce_op_e       op_q,
    output logic             busy,
    output logic             result_stb
);

    reduce_state_e state_q;
    reduce_state_e state_d;

    // A start only counts when idle and with something to reduce
    logic start_ok;

    ////////////////////////////////////////////////////////////////////////////
    // Strobe decode
    ////////////////////////////////////////////////////////////////////////////

    assign start_ok = start && (state_q == ST_IDLE) && (count != '0);
    assign clear    = start_ok;

    // Strobes outside a job fall through here
    assign load_first = in_stb && (state_q == ST_FIRST);
    assign update     = in_stb && (state_q == ST_ACCUM);
    assign step       = load_first || update;

    // DONE is the result cycle, busy is already low there
    assign busy       = (state_q == ST_FIRST) || (state_q == ST_ACCUM);
    assign result_stb = (state_q == ST_DONE);

    ////////////////////////////////////////////////////////////////////////////
    // State sequencing
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (start_ok) begin
                    state_d = ST_FIRST;
                end
            end
            ST_FIRST: begin
                if (in_stb) begin
                    state_d = last ? ST_DONE : ST_ACCUM;
                end
            end
            ST_ACCUM: begin
                if (in_stb && last) begin
                    state_d = ST_DONE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Operation held for the whole job
    always_ff @(posedge clk) begin
        if (rst) begin
            op_q <= OP_MAX;
        end else if (start_ok) begin
            op_q <= op;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    a_result_stb_single: assert property (
        @(posedge clk) disable iff (rst)
        result_stb |=> !result_stb
    ) else $error("reduce_ctrl_fsm: result_stb longer than one cycle");

    a_load_update_excl: assert property (
        @(posedge clk) disable iff (rst)
        !(load_first && update)
    ) else $error("reduce_ctrl_fsm: load_first and update together");

endmodule

// ==== fp_extreme_acc.sv ====
module fp_extreme_acc
    import fp_reduce_pkg::*;
#(
    parameter int LEN_W = 8
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             load_first,
    input  logic             update,
    input  reduce_op_e       op,
    input  logic [FP_W-1:0]  in_data,
    input  logic [LEN_W-1:0] index,
    output logic [FP_W-1:0]  acc_value,
    output logic [LEN_W-1:0] acc_index
);

    // Exponent, hidden one and fraction as one magnitude key
    localparam int MAG_W = EXP_W + 1 + MAN_W;

    ////////////////////////////////////////////////////////////////////////////
    // Field split
    ////////////////////////////////////////////////////////////////////////////

    logic             new_s;
    logic             old_s;
    logic [EXP_W-1:0] new_e;
    logic [EXP_W-1:0] old_e;
    logic [MAN_W:0]   new_m;
    logic [MAN_W:0]   old_m;
    logic [MAG_W-1:0] new_mag;
    logic [MAG_W-1:0] old_mag;

    assign new_s = in_data[FP_W-1];
    assign old_s = acc_value[FP_W-1];
    assign new_e = in_data[FP_W-2 -: EXP_W];
    assign old_e = acc_value[FP_W-2 -: EXP_W];

    // Denormals get the hidden one too
    assign new_m = {1'b1, in_data[MAN_W-1:0]};
    assign old_m = {1'b1, acc_value[MAN_W-1:0]};

    // Exponent in the upper bits, so it decides before the mantissa
    assign new_mag = {new_e, new_m};
    assign old_mag = {old_e, old_m};

    ////////////////////////////////////////////////////////////////////////////
    // Ordering of new element against held value
    ////////////////////////////////////////////////////////////////////////////

    logic mag_gt;
    logic mag_lt;
    logic new_gt;
    logic new_lt;
    logic take;

    assign mag_gt = (new_mag > old_mag);
    assign mag_lt = (new_mag < old_mag);

    always_comb begin
        if (new_s != old_s) begin
            // Positive side wins, +0 above -0
            new_gt = !new_s;
            new_lt = new_s;
        end else if (!new_s) begin
            new_gt = mag_gt;
            new_lt = mag_lt;
        end else begin
            // Both negative, larger magnitude is the smaller value
            new_gt = mag_lt;
            new_lt = mag_gt;
        end
    end

    // Strict compare, ties keep the earlier element
    assign take = (op == OP_MAX) ? new_gt : new_lt;

    ////////////////////////////////////////////////////////////////////////////
    // Held extreme and its position
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            acc_value <= '0;
            acc_index <= '0;
        end else if (load_first || (update && take)) begin
            acc_value <= in_data;
            acc_index <= index;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    // Result must hold between jobs and across idle gaps
    a_hold_when_idle: assert property (
        @(posedge clk) disable iff (rst)
        (!load_first && !update) |=> ($stable(acc_value) && $stable(acc_index))
    ) else $error("fp_extreme_acc: held value changed without a strobe");

endmodule

// ==== fp_reduce_top.sv ====
module fp_reduce_top
    import fp_reduce_pkg::*;
#(
    parameter int LEN_W = 8
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  reduce_op_e       op,
    input  logic [LEN_W-1:0] count,
    input  logic             in_stb,
    input  logic [FP_W-1:0]  in_data,
    output logic             busy,
    output logic             result_stb,
    output logic [FP_W-1:0]  result,
    output logic [LEN_W-1:0] result_index
);

    ////////////////////////////////////////////////////////////////////////////
    // Internal control
    ////////////////////////////////////////////////////////////////////////////

    logic             clear;
    logic             step;
    logic             load_first;
    logic             update;
    reduce_op_e       op_q;
    logic [LEN_W-1:0] index;
    logic             last;
    logic [FP_W-1:0]  acc_value;
    logic [LEN_W-1:0] acc_index;

    reduce_ctrl_fsm #(
        .LEN_W (LEN_W)
    ) u_reduce_ctrl_fsm (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .op         (op),
        .count      (count),
        .in_stb     (in_stb),
        .last       (last),
        .clear      (clear),
        .step       (step),
        .load_first (load_first),
        .update     (update),
        .op_q       (op_q),
        .busy       (busy),
        .result_stb (result_stb)
    );

    // Position of each accepted element within the job
    element_counter #(
        .LEN_W (LEN_W)
    ) u_element_counter (
        .clk   (clk),
        .rst   (rst),
        .clear (clear),
        .step  (step),
        .count (count),
        .index (index),
        .last  (last)
    );

    fp_extreme_acc #(
        .LEN_W (LEN_W)
    ) u_fp_extreme_acc (
        .clk        (clk),
        .rst        (rst),
        .load_first (load_first),
        .update     (update),
        .op         (op_q),
        .in_data    (in_data),
        .index      (index),
        .acc_value  (acc_value),
        .acc_index  (acc_index)
    );

    // Held pair doubles as the result
    assign result       = acc_value;
    assign result_index = acc_index;

endmodule

// ==== tb_clock_gen.sv ====
module tb_clock_gen #(
    parameter int PERIOD = 20
) (
    output logic clk
);

    // Free-running clock, low at time zero
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

endmodule

// ==== tb_fp_reduce.sv ====
module tb_fp_reduce
    import fp_reduce_pkg::*;
();

    localparam int    LEN_W     = 8;
    localparam string STIM_FILE = "fp_reduce_stim.txt";

    logic             clk;
    logic             rst;
    logic             start;
    reduce_op_e       op;
    logic [LEN_W-1:0] count;
    logic             in_stb;
    logic [FP_W-1:0]  in_data;
    logic             busy;
    logic             result_stb;
    logic [FP_W-1:0]  result;
    logic [LEN_W-1:0] result_index;

    // One entry per stimulus data line
    logic [7:0]  rec_kind[$];
    logic [31:0] rec_a[$];
    logic [31:0] rec_b[$];

    int          line_count     = 0;
    int          cycle_count    = 0;
    int          cycle_limit    = 0;
    int          mismatch_count = 0;
    int          other_count    = 0;
    int unsigned lcg_state;

    tb_clock_gen #(
        .PERIOD (20)
    ) u_tb_clock_gen (
        .clk (clk)
    );

    fp_reduce_top #(
        .LEN_W (LEN_W)
    ) u_fp_reduce_top (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .op           (op),
        .count        (count),
        .in_stb       (in_stb),
        .in_data      (in_data),
        .busy         (busy),
        .result_stb   (result_stb),
        .result       (result),
        .result_index (result_index)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    task automatic report_failure(string msg);
        $display("error at %0t: %s", $time, msg);
        other_count++;
    endtask

    task automatic load_stimulus();
        int          fd;
        int          n;
        string       line;
        logic [7:0]  kind;
        logic [31:0] a;
        logic [31:0] b;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            report_failure("could not open the stimulus file");
            return;
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0) begin
                line_count++;
                kind = line.getc(0);
                // Comment and blank lines carry no record
                if (kind == "S" || kind == "E" || kind == "R") begin
                    a = '0;
                    b = '0;
                    n = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, b);
                    rec_kind.push_back(kind);
                    rec_a.push_back(a);
                    rec_b.push_back(b);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        start  <= 1'b0;
        in_stb <= 1'b0;
    endtask

    // Start pulse, then busy one cycle later if the count is nonzero
    task automatic issue_start(reduce_op_e job_op, logic [LEN_W-1:0] job_count);
        @(posedge clk);
        start  <= 1'b1;
        op     <= job_op;
        count  <= job_count;
        in_stb <= 1'b0;
        @(negedge clk);
        if (busy !== 1'b0) report_failure("busy high while a start was presented");
        idle_cycle();
        @(negedge clk);
        if (job_count != '0 && busy !== 1'b1) report_failure("busy did not rise after start");
        if (job_count == '0 && busy !== 1'b0) report_failure("start with count zero set busy");
    endtask

    task automatic run_job(reduce_op_e job_op, logic [LEN_W-1:0] job_count,
                           logic [31:0] elems[$], logic [31:0] exp_value,
                           logic [LEN_W-1:0] exp_index);
        int gap;
        bit seen;
        issue_start(job_op, job_count);
        foreach (elems[i]) begin
            gap = int'(lcg_next() % 4);
            repeat (gap) begin
                idle_cycle();
                @(negedge clk);
                if (busy !== 1'b1 || result_stb !== 1'b0) begin
                    report_failure("job ended before its last element");
                end
            end
            @(posedge clk);
            in_stb  <= 1'b1;
            in_data <= elems[i];
            @(negedge clk);
            if (result_stb !== 1'b0) report_failure("result strobe before the last element");
            if (busy !== 1'b1) report_failure("busy low while elements were still due");
        end
        idle_cycle();
        @(negedge clk);
        seen = result_stb;
        if (!seen) begin
            report_failure("result strobe not one cycle after the last element");
            idle_cycle();
            @(negedge clk);
            seen = result_stb;
        end
        if (!seen) begin
            report_failure("no result strobe within two cycles of the last element");
        end else begin
            if (busy !== 1'b0) report_failure("busy still high at the result strobe");
            if (result !== exp_value) begin
                $display("mismatch at %0t: result expected %08h, got %08h",
                         $time, exp_value, result);
                mismatch_count++;
            end
            if (result_index !== exp_index) begin
                $display("mismatch at %0t: index expected %0d, got %0d",
                         $time, exp_index, result_index);
                mismatch_count++;
            end
            idle_cycle();
            @(negedge clk);
            if (result_stb !== 1'b0) report_failure("result strobe lasted more than one cycle");
        end
    endtask

    // Strobes between jobs must be dropped and leave the result alone
    task automatic stray_strobes();
        logic [31:0]      held_value;
        logic [LEN_W-1:0] held_index;
        held_value = result;
        held_index = result_index;
        repeat (2) begin
            @(posedge clk);
            in_stb  <= 1'b1;
            in_data <= lcg_next();
            @(negedge clk);
            if (busy !== 1'b0 || result_stb !== 1'b0) report_failure("idle strobe woke the unit");
        end
        idle_cycle();
        @(negedge clk);
        if (busy !== 1'b0) report_failure("idle strobe woke the unit");
        if (result !== held_value) report_failure("result changed while idle");
        if (result_index !== held_index) report_failure("result index changed while idle");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Timeout
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("error: run did not finish within %0d cycles (%0d mismatches, %0d other)",
                     cycle_limit, mismatch_count, other_count);
            $display("=== FAIL ===");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int               i;
        int               jobs;
        logic [31:0]      elems[$];
        logic [LEN_W-1:0] job_count;
        reduce_op_e       job_op;
        rst       = 1'b1;
        start     = 1'b0;
        op        = OP_MAX;
        count     = '0;
        in_stb    = 1'b0;
        in_data   = '0;
        lcg_state = 6;
        jobs      = 0;
        load_stimulus();
        cycle_limit = 10 * line_count + 200;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        if (busy !== 1'b0 || result_stb !== 1'b0 || result !== '0 || result_index !== '0) begin
            report_failure("outputs not cleared by reset");
        end
        i = 0;
        while (i < rec_kind.size()) begin
            if (rec_kind[i] != "S") begin
                report_failure("stimulus line out of order");
                i++;
            end else begin
                job_op    = reduce_op_e'(rec_a[i][0]);
                job_count = rec_b[i][LEN_W-1:0];
                i++;
                elems.delete();
                while (i < rec_kind.size() && rec_kind[i] == "E") begin
                    elems.push_back(rec_a[i]);
                    i++;
                end
                if (elems.size() != int'(job_count)) report_failure("element count off in file");
                if (job_count == '0) begin
                    issue_start(job_op, job_count);
                    idle_cycle();
                    @(negedge clk);
                    if (busy !== 1'b0 || result_stb !== 1'b0) begin
                        report_failure("empty job produced activity");
                    end
                end else if (i < rec_kind.size() && rec_kind[i] == "R") begin
                    run_job(job_op, job_count, elems, rec_a[i], rec_b[i][LEN_W-1:0]);
                    i++;
                end else begin
                    report_failure("job in file has no expected result");
                end
                jobs++;
                stray_strobes();
            end
        end
        $display("summary: %0d jobs, %0d mismatches, %0d other errors",
                 jobs, mismatch_count, other_count);
        if (mismatch_count + other_count == 0 && jobs > 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== fp_reduce_stim.txt ====
# S <op 0=max 1=min> <count hex> | E <element hex>
# R <expected value hex> <expected index hex>
S 0 5
E C2C80000
E 3F800000
E BF000000
E 40200000
E 40000000
R 40200000 3
S 0 4
E 3FA00000
E 3FE00000
E 3F800001
E 3FE00001
R 3FE00001 3
S 1 5
E BF800000
E C0400000
E BFE00000
E C0800000
E C0000000
R C0800000 3
S 0 4
E 40000000
E 40400000
E 3F800000
E 40400000
R 40400000 1
S 1 4
E 3F800000
E BF800000
E 40000000
E BF800000
R BF800000 1
S 0 3
E 80000000
E 00000000
E 80000000
R 00000000 1
S 1 3
E 00000000
E 80000000
E 00000000
R 80000000 1
S 1 1
E 42C80000
R 42C80000 0
S 0 0
S 1 4
E 3F800000
E BF000000
E 40000000
E 3F000000
R BF000000 1

// ==== build.f ====
fp_reduce_pkg.sv
element_counter.sv
reduce_ctrl_fsm.sv
fp_extreme_acc.sv
fp_reduce_top.sv
tb_clock_gen.sv
tb_fp_reduce.sv

// ==== Makefile ====
SIM       ?= verilator
SIM_FLAGS ?= --binary --timing --assert
TOP       ?= tb_fp_reduce
FILE_LIST ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "=== PASS ===" $(LOG); then \
		echo "simulation did not complete, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
